//--- common/sdram_pkg.sv
/*
 * Shared definitions for the two-port SDRAM controller.
 * Holds chip geometry and timing, the command encoding, the mode word
 * and the tag that follows each access down the pipeline.
 */
package sdram_pkg;

	// Geometry of the 16-bit single-chip part
	localparam int ROW_BITS = 13;
	localparam int COL_BITS = 9;
	localparam int WORD_ADDR_BITS = ROW_BITS + COL_BITS;
	localparam int BA_BITS = 2;
	localparam int NUM_BANKS_USED = 2;
	// A10 requests auto-precharge on READ/WRITE and selects all banks on PRECHARGE
	localparam int AP_BIT = 10;

	typedef logic [WORD_ADDR_BITS-1:0] addr_t;
	typedef logic [ROW_BITS-1:0] row_t;
	typedef logic [COL_BITS-1:0] col_t;
	typedef logic [15:0] data_t;

	// Bit order is nCS, nRAS, nCAS, nWE
	typedef enum logic [3:0] {
		CMD_LOAD_MODE    = 4'b0000,
		CMD_AUTO_REFRESH = 4'b0001,
		CMD_PRECHARGE    = 4'b0010,
		CMD_ACTIVE       = 4'b0011,
		CMD_WRITE        = 4'b0100,
		CMD_READ         = 4'b0101,
		CMD_NOP          = 4'b0111,
		CMD_INHIBIT      = 4'b1111
	} cmd_t;

	// Burst 1, sequential, CL2, standard operation, single-access writes
	localparam row_t MODE_WORD = 13'h220;
	localparam int CAS_LATENCY = 2;

	// Bank occupancy in cycles, from tRC and from tWR plus tRP
	localparam int BANK_DELAY = 5;
	localparam int BANK_WRITE_DELAY = 4;
	localparam int BUSY_BITS = $clog2(BANK_DELAY + 1);

	// Power-up sequence, counted down from INIT_STEPS
	localparam int INIT_STEPS = 31;
	localparam int INIT_BITS = $clog2(INIT_STEPS + 1);
	localparam int INIT_STEP_PRECHARGE = 15;
	localparam int INIT_STEP_REFRESH_FIRST = 11;
	localparam int INIT_STEP_REFRESH_LAST = 4;
	localparam int INIT_STEP_MODE = 2;

	// Per-bank refresh interval, short for simulation
	// Silicon value comes from 64 ms spread over 8192 rows
	localparam int REFRESH_TICKS = 96;
	localparam int REFRESH_FORCE_TICKS = REFRESH_TICKS - 4;
	localparam int REFRESH_CNT_BITS = $clog2(REFRESH_TICKS + 1);

	// Owner of a pipeline slot
	typedef enum logic [1:0] {
		PORT_NONE    = 2'd0,
		PORT_CPU     = 2'd1,
		PORT_VID     = 2'd2,
		PORT_REFRESH = 2'd3
	} port_id_t;

endpackage

//--- common/bank_req_if.sv
/*
 * One bank's pending access, offered by its bank queue to the sequencer.
 * The sequencer answers with a single-cycle taken pulse.
 */
interface bank_req_if
	import sdram_pkg::*;
();

	logic pending;
	logic wr;
	port_id_t port;
	row_t row;
	col_t col;
	data_t wdata;
	// req level that the entry will mark as serviced
	logic toggle;
	logic taken;

	modport queue (
		output pending, wr, port, row, col, wdata, toggle,
		input taken
	);

	modport seq (
		input pending, wr, port, row, col, wdata,
		output taken
	);

endinterface

//--- hw/sdram_ctrl/refresh_timer.sv
/*
 * Refresh interval timer for one bank.
 * need rises every REFRESH_TICKS cycles, forced follows if it is still
 * pending near the next deadline. done clears both and steps the row.
 */
module refresh_timer
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic init_n,
	input  logic done,
	output logic need,
	output logic forced,
	output row_t row
);

	logic [REFRESH_CNT_BITS-1:0] count;

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			count <= '0;
			need <= 1'b0;
			forced <= 1'b0;
			row <= '0;
		end else begin
			count <= count + 1'b1;

			// Refresh slot reached CAS, move to the next row
			if (done) begin
				need <= 1'b0;
				forced <= 1'b0;
				row <= row + 1'b1;
			end

			if (count == REFRESH_CNT_BITS'(REFRESH_FORCE_TICKS))
				forced <= need && !done;

			if (count == REFRESH_CNT_BITS'(REFRESH_TICKS)) begin
				need <= 1'b1;
				count <= '0;
			end
		end
	end

endmodule

//--- hw/sdram_ctrl/bank_queue.sv
/*
 * Request holder for one bank.
 * Offers either the client's access or a refresh of refresh_row,
 * and remembers the req level that was last serviced.
 */
module bank_queue
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic init_n,
	input  logic req,
	input  logic we,
	input  addr_t addr,
	input  data_t din,
	input  port_id_t tag,
	input  logic refresh_need,
	input  logic refresh_force,
	input  row_t refresh_row,
	bank_req_if.queue bank
);

	// req level at the last taken client access
	logic serviced;
	logic client_due;

	// A forced refresh holds the client off for one take
	assign client_due = (req != serviced) && !refresh_force;

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			serviced <= 1'b0;
			bank.pending <= 1'b0;
			bank.wr <= 1'b0;
			bank.port <= PORT_NONE;
		end else begin
			if (bank.taken)
				serviced <= bank.toggle;

			if (client_due) begin
				bank.pending <= 1'b1;
				bank.wr <= we;
				bank.port <= tag;
			end else begin
				// Idle slot, offer a refresh if one is due
				bank.pending <= refresh_need;
				bank.wr <= 1'b0;
				bank.port <= PORT_REFRESH;
			end
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (client_due) begin
			bank.row <= addr[WORD_ADDR_BITS-1:COL_BITS];
			bank.col <= addr[COL_BITS-1:0];
			bank.wdata <= din;
			bank.toggle <= req;
		end else begin
			bank.row <= refresh_row;
			// refresh leaves the serviced level where it is
			bank.toggle <= serviced;
		end
	end

endmodule

//--- hw/sdram_ctrl/cmd_sequencer.sv
/*
 * Command sequencer: power-up sequence, bank busy counters, arbitration
 * and the RAS/CAS/MASK pipeline that drives the chip pins.
 * ACTIVE in cycle t, READ or WRITE with auto-precharge in t+2.
 */
module cmd_sequencer
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic init_n,
	bank_req_if.seq bank0,
	bank_req_if.seq bank1,
	output logic [NUM_BANKS_USED-1:0] refresh_done,
	output port_id_t ras_tag,
	output logic ras_wr,
	output port_id_t mask_tag,
	output cmd_t sd_cmd,
	output row_t sd_a,
	output logic [BA_BITS-1:0] sd_ba,
	output logic [1:0] sd_dqm,
	output data_t sd_dq_out,
	output logic sd_dq_oe
);

	logic in_init;
	logic [INIT_BITS-1:0] init_step;
	logic [BUSY_BITS-1:0] busy [NUM_BANKS_USED];

	// Pipeline stages, s1 and s2 form RAS, cas carries the issued command
	port_id_t s1_tag, s2_tag, cas_tag;
	logic s1_wr, s2_wr, cas_wr;
	logic s1_bank, s2_bank, cas_bank;
	col_t s1_col, s2_col;
	data_t s1_wdata, s2_wdata;

	logic slot_free;
	logic cas_read;
	logic [NUM_BANKS_USED-1:0] ready;
	logic grant0, grant1, grant;
	port_id_t sel_port;
	logic sel_wr;
	logic sel_bank;
	row_t sel_row;
	col_t sel_col;
	data_t sel_wdata;

	// Free slot when both RAS stages are empty, so ACTIVE never meets a CAS command
	assign slot_free = !in_init && (s1_tag == PORT_NONE) && (s2_tag == PORT_NONE);
	// Read (or refresh) activated in the previous slot
	assign cas_read = (cas_tag != PORT_NONE) && !cas_wr;

	// No write right after a read, keeps the data bus turnaround clean
	assign ready[0] = bank0.pending && (busy[0] == '0) && !(bank0.wr && cas_read);
	assign ready[1] = bank1.pending && (busy[1] == '0) && !(bank1.wr && cas_read);

	// vid bank first
	assign grant1 = slot_free && ready[1];
	assign grant0 = slot_free && ready[0] && !ready[1];
	assign grant = grant0 || grant1;
	assign bank0.taken = grant0;
	assign bank1.taken = grant1;

	always_comb begin
		sel_bank = grant1;
		if (grant1) begin
			sel_port = bank1.port;
			sel_wr = bank1.wr;
			sel_row = bank1.row;
			sel_col = bank1.col;
			sel_wdata = bank1.wdata;
		end else begin
			sel_port = bank0.port;
			sel_wr = bank0.wr;
			sel_row = bank0.row;
			sel_col = bank0.col;
			sel_wdata = bank0.wdata;
		end
	end

	assign ras_tag = s2_tag;
	assign ras_wr = s2_wr;

	// refresh slot at CAS frees the timer for its bank
	always_comb begin
		for (int b = 0; b < NUM_BANKS_USED; b++)
			refresh_done[b] = (cas_tag == PORT_REFRESH) && (int'(cas_bank) == b);
	end

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			sd_cmd <= CMD_INHIBIT;
			sd_dqm <= 2'b11;
			sd_dq_oe <= 1'b0;
			in_init <= 1'b1;
			init_step <= INIT_BITS'(INIT_STEPS);
			for (int b = 0; b < NUM_BANKS_USED; b++)
				busy[b] <= BUSY_BITS'(BANK_DELAY);
			s1_tag <= PORT_NONE;
			s2_tag <= PORT_NONE;
			cas_tag <= PORT_NONE;
			mask_tag <= PORT_NONE;
			s1_wr <= 1'b0;
			s2_wr <= 1'b0;
			cas_wr <= 1'b0;
			s1_bank <= 1'b0;
			s2_bank <= 1'b0;
			cas_bank <= 1'b0;
		end else begin
			for (int b = 0; b < NUM_BANKS_USED; b++)
				if (busy[b] != '0)
					busy[b] <= busy[b] - 1'b1;
			sd_dqm <= 2'b11;
			sd_dq_oe <= 1'b0;

			if (in_init) begin
				sd_cmd <= CMD_INHIBIT;
				// Bank 0 counter paces the init steps
				if (busy[0] == '0) begin
					case (init_step) inside
						INIT_BITS'(INIT_STEP_PRECHARGE): sd_cmd <= CMD_PRECHARGE;
						[INIT_BITS'(INIT_STEP_REFRESH_LAST):INIT_BITS'(INIT_STEP_REFRESH_FIRST)]:
							sd_cmd <= CMD_AUTO_REFRESH;
						INIT_BITS'(INIT_STEP_MODE): sd_cmd <= CMD_LOAD_MODE;
						default: ;
					endcase
					busy[0] <= BUSY_BITS'(BANK_DELAY);
					init_step <= init_step - 1'b1;
					if (init_step == '0) begin
						in_init <= 1'b0;
						busy[0] <= '0;
					end
				end
			end else begin
				sd_cmd <= CMD_NOP;

				// RAS
				s1_tag <= grant ? sel_port : PORT_NONE;
				s1_wr <= grant && sel_wr;
				s1_bank <= sel_bank;
				s2_tag <= s1_tag;
				s2_wr <= s1_wr;
				s2_bank <= s1_bank;
				if (grant) begin
					sd_cmd <= CMD_ACTIVE;
					busy[sel_bank] <= BUSY_BITS'(BANK_DELAY);
				end

				// CAS, issued from the second RAS stage
				cas_tag <= s2_tag;
				cas_wr <= s2_wr;
				cas_bank <= s2_bank;
				if (s2_tag != PORT_NONE) begin
					sd_cmd <= s2_wr ? CMD_WRITE : CMD_READ;
					// refresh reads keep the DQ pins off
					if (s2_tag != PORT_REFRESH)
						sd_dqm <= 2'b00;
					if (s2_wr) begin
						sd_dq_oe <= 1'b1;
						busy[s2_bank] <= BUSY_BITS'(BANK_WRITE_DELAY);
					end
				end

				// MASK, writes end here
				mask_tag <= cas_wr ? PORT_NONE : cas_tag;
			end
		end
	end

	// Address, bank and write data pins plus the column and data stages
	always_ff @(posedge clk) begin
		s2_col <= s1_col;
		s2_wdata <= s1_wdata;
		if (in_init) begin
			if (busy[0] == '0) begin
				if (init_step == INIT_BITS'(INIT_STEP_PRECHARGE)) begin
					sd_a <= '0;
					sd_a[AP_BIT] <= 1'b1;
				end
				if (init_step == INIT_BITS'(INIT_STEP_MODE)) begin
					sd_a <= MODE_WORD;
					sd_ba <= '0;
				end
			end
		end else begin
			if (grant) begin
				sd_a <= sel_row;
				sd_ba <= BA_BITS'(sel_bank);
				s1_col <= sel_col;
				s1_wdata <= sel_wdata;
			end
			if (s2_tag != PORT_NONE) begin
				sd_a <= '0;
				sd_a[COL_BITS-1:0] <= s2_col;
				sd_a[AP_BIT] <= 1'b1;
				sd_ba <= BA_BITS'(s2_bank);
				sd_dq_out <= s2_wdata;
			end
		end
	end

endmodule

//--- hw/sdram_ctrl/read_return.sv
/*
 * Return path: registers chip data, runs the latch stages and answers
 * each client. Write ack lands at t+3, read ack and data at t+6.
 */
module read_return
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic init_n,
	input  port_id_t ras_tag,
	input  logic ras_wr,
	input  port_id_t mask_tag,
	input  data_t sd_dq_in,
	input  logic cpu_req,
	input  logic vid_req,
	output logic cpu_ack,
	output logic vid_ack,
	output data_t cpu_dout,
	output data_t vid_dout
);

	data_t din_r;
	// write tag one cycle past RAS2
	port_id_t wr_tag;
	// one latch stage per cycle of CAS latency
	port_id_t latch_tag [CAS_LATENCY];
	port_id_t rd_tag;

	assign rd_tag = latch_tag[CAS_LATENCY-1];

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			wr_tag <= PORT_NONE;
			for (int i = 0; i < CAS_LATENCY; i++)
				latch_tag[i] <= PORT_NONE;
			cpu_ack <= 1'b0;
			vid_ack <= 1'b0;
		end else begin
			wr_tag <= ras_wr ? ras_tag : PORT_NONE;
			latch_tag[0] <= mask_tag;
			for (int i = 1; i < CAS_LATENCY; i++)
				latch_tag[i] <= latch_tag[i-1];

			if (wr_tag == PORT_CPU || rd_tag == PORT_CPU)
				cpu_ack <= cpu_req;
			if (wr_tag == PORT_VID || rd_tag == PORT_VID)
				vid_ack <= vid_req;
		end
	end

	// Read word moves to the port together with its ack
	always_ff @(posedge clk) begin
		din_r <= sd_dq_in;
		if (rd_tag == PORT_CPU)
			cpu_dout <= din_r;
		if (rd_tag == PORT_VID)
			vid_dout <= din_r;
	end

endmodule

//--- hw/sdram_ctrl/sdram_ctrl.sv
/*
 * Two-port SDRAM controller top level.
 * cpu owns bank 0, vid owns bank 1 and wins arbitration.
 * Clients use a toggle handshake: the access is done when ack equals req.
 */
module sdram_ctrl
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic init_n,

	input  logic cpu_req,
	output logic cpu_ack,
	input  logic cpu_we,
	input  addr_t cpu_addr,
	input  data_t cpu_din,
	output data_t cpu_dout,

	input  logic vid_req,
	output logic vid_ack,
	input  logic vid_we,
	input  addr_t vid_addr,
	input  data_t vid_din,
	output data_t vid_dout,

	output cmd_t sd_cmd,
	output row_t sd_a,
	output logic [BA_BITS-1:0] sd_ba,
	output logic [1:0] sd_dqm,
	output data_t sd_dq_out,
	output logic sd_dq_oe,
	input  data_t sd_dq_in
);

	logic [NUM_BANKS_USED-1:0] refresh_need;
	logic [NUM_BANKS_USED-1:0] refresh_force;
	logic [NUM_BANKS_USED-1:0] refresh_done;
	row_t refresh_row [NUM_BANKS_USED];
	port_id_t ras_tag;
	logic ras_wr;
	port_id_t mask_tag;

	bank_req_if bank0_if ();
	bank_req_if bank1_if ();

	// One row-walking refresh timer per bank
	for (genvar b = 0; b < NUM_BANKS_USED; b++) begin : g_refresh
		refresh_timer u_timer (
			.clk    (clk),
			.init_n (init_n),
			.done   (refresh_done[b]),
			.need   (refresh_need[b]),
			.forced (refresh_force[b]),
			.row    (refresh_row[b])
		);
	end

	// Bank 0 queue serves cpu
	bank_queue u_queue0 (
		.clk           (clk),
		.init_n        (init_n),
		.req           (cpu_req),
		.we            (cpu_we),
		.addr          (cpu_addr),
		.din           (cpu_din),
		.tag           (PORT_CPU),
		.refresh_need  (refresh_need[0]),
		.refresh_force (refresh_force[0]),
		.refresh_row   (refresh_row[0]),
		.bank          (bank0_if.queue)
	);

	// Bank 1 queue serves vid
	bank_queue u_queue1 (
		.clk           (clk),
		.init_n        (init_n),
		.req           (vid_req),
		.we            (vid_we),
		.addr          (vid_addr),
		.din           (vid_din),
		.tag           (PORT_VID),
		.refresh_need  (refresh_need[1]),
		.refresh_force (refresh_force[1]),
		.refresh_row   (refresh_row[1]),
		.bank          (bank1_if.queue)
	);

	cmd_sequencer u_seq (
		.clk          (clk),
		.init_n       (init_n),
		.bank0        (bank0_if.seq),
		.bank1        (bank1_if.seq),
		.refresh_done (refresh_done),
		.ras_tag      (ras_tag),
		.ras_wr       (ras_wr),
		.mask_tag     (mask_tag),
		.sd_cmd       (sd_cmd),
		.sd_a         (sd_a),
		.sd_ba        (sd_ba),
		.sd_dqm       (sd_dqm),
		.sd_dq_out    (sd_dq_out),
		.sd_dq_oe     (sd_dq_oe)
	);

	read_return u_return (
		.clk      (clk),
		.init_n   (init_n),
		.ras_tag  (ras_tag),
		.ras_wr   (ras_wr),
		.mask_tag (mask_tag),
		.sd_dq_in (sd_dq_in),
		.cpu_req  (cpu_req),
		.vid_req  (vid_req),
		.cpu_ack  (cpu_ack),
		.vid_ack  (vid_ack),
		.cpu_dout (cpu_dout),
		.vid_dout (vid_dout)
	);

endmodule

//--- tests/sdram_model.sv
/*
 * Behavioral SDRAM for simulation of the controller.
 * Decodes commands, stores written words, returns read data two cycles
 * after READ and counts protocol errors in proto_errors.
 */
module sdram_model
	import sdram_pkg::*;
(
	input  logic clk,
	input  cmd_t cmd,
	input  row_t a,
	input  logic [BA_BITS-1:0] ba,
	input  logic [1:0] dqm,
	input  data_t dq_out,
	input  logic dq_oe,
	output data_t dq_in
);

	// Sparse storage keyed by bank, row and column
	data_t mem [logic [23:0]];
	logic bank_open [4];
	row_t open_row [4];
	int last_act [4];
	int last_read;
	int cyc;
	bit mode_set;
	data_t rd_stage;
	int proto_errors;

	initial begin
		for (int b = 0; b < 4; b++) begin
			bank_open[b] = 1'b0;
			open_row[b] = '0;
			last_act[b] = -100;
		end
		last_read = -100;
		cyc = 0;
		mode_set = 1'b0;
		rd_stage = '0;
		proto_errors = 0;
		dq_in = '0;
	end

	function automatic data_t peek(input logic [1:0] b, input row_t r, input col_t c);
		logic [23:0] key;
		key = {b, r, c};
		if (mem.exists(key))
			return mem[key];
		return '0;
	endfunction

	task automatic flag(input string msg);
		$display("Protocol error at time %0t: %s", $time, msg);
		proto_errors++;
	endtask

	always @(posedge clk) begin
		cyc++;
		// Second stage of the CAS latency
		dq_in <= rd_stage;
		rd_stage <= '0;
		case (cmd)
			CMD_ACTIVE: begin
				if (!mode_set)
					flag("ACTIVE before the mode register was loaded");
				if (bank_open[ba])
					flag("ACTIVE to a bank that is still open");
				if (cyc - last_act[ba] < BANK_DELAY)
					flag("ACTIVE to the same bank before tRC elapsed");
				bank_open[ba] = 1'b1;
				open_row[ba] = a;
				last_act[ba] = cyc;
			end
			CMD_READ: begin
				if (!bank_open[ba])
					flag("READ to a closed bank");
				if (!a[AP_BIT])
					flag("READ without auto-precharge");
				// Output buffers only on with DQM low
				if (dqm == 2'b00)
					rd_stage <= peek(ba, open_row[ba], a[COL_BITS-1:0]);
				last_read = cyc;
				bank_open[ba] = 1'b0;
			end
			CMD_WRITE: begin
				if (!bank_open[ba])
					flag("WRITE to a closed bank");
				if (!a[AP_BIT])
					flag("WRITE without auto-precharge");
				if (!dq_oe)
					flag("WRITE with the data pins not driven");
				// Write activated right after a read would clash on DQ
				if (cyc - last_read < 4)
					flag("WRITE issued in the slot after a read");
				mem[{ba, open_row[ba], a[COL_BITS-1:0]}] = dq_out;
				bank_open[ba] = 1'b0;
			end
			CMD_PRECHARGE: begin
				if (a[AP_BIT]) begin
					for (int b = 0; b < 4; b++)
						bank_open[b] = 1'b0;
				end else
					bank_open[ba] = 1'b0;
			end
			CMD_AUTO_REFRESH: begin
				for (int b = 0; b < 4; b++)
					if (bank_open[b])
						flag("AUTO_REFRESH with a bank open");
			end
			CMD_LOAD_MODE: mode_set = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- tests/tb_sdram_ctrl.sv
/*
 * Directed testbench for the two-port SDRAM controller.
 * A pin monitor checks init order, command spacing, ack timing and refresh;
 * the tasks drive both client ports and compare read data.
 */
module tb_sdram_ctrl;
	import sdram_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	// need is forced only about one interval after it rises
	localparam int REFRESH_MARGIN = REFRESH_TICKS + 24;
	localparam int NUM_OPS = 20;

	logic clk;
	logic init_n;
	logic cpu_req, cpu_we, vid_req, vid_we;
	logic cpu_ack, vid_ack;
	addr_t cpu_addr, vid_addr;
	data_t cpu_din, vid_din, cpu_dout, vid_dout;
	cmd_t sd_cmd;
	row_t sd_a;
	logic [BA_BITS-1:0] sd_ba;
	logic [1:0] sd_dqm;
	data_t sd_dq_out, sd_dq_in;
	logic sd_dq_oe;

	integer seed;
	int errors;
	int cyc;

	// Monitor state
	bit saw_precharge, saw_mode;
	int init_refreshes;
	int act_cyc [2];
	logic act_open [2];
	row_t act_row [2];
	int ack_due [2];
	logic prev_ack [2];
	int refresh_count [2];
	int refresh_last [2];
	row_t refresh_row_exp [2];

	// Pre-generated two-port traffic
	logic op_we [2][NUM_OPS];
	addr_t op_addr [2][NUM_OPS];
	data_t op_data [2][NUM_OPS];
	addr_t addr_table [4];

	sdram_ctrl UUT (
		.clk(clk), .init_n(init_n),
		.cpu_req(cpu_req), .cpu_ack(cpu_ack), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_dout(cpu_dout),
		.vid_req(vid_req), .vid_ack(vid_ack), .vid_we(vid_we),
		.vid_addr(vid_addr), .vid_din(vid_din), .vid_dout(vid_dout),
		.sd_cmd(sd_cmd), .sd_a(sd_a), .sd_ba(sd_ba), .sd_dqm(sd_dqm),
		.sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe), .sd_dq_in(sd_dq_in)
	);

	sdram_model model (
		.clk(clk), .cmd(sd_cmd), .a(sd_a), .ba(sd_ba), .dqm(sd_dqm),
		.dq_out(sd_dq_out), .dq_oe(sd_dq_oe), .dq_in(sd_dq_in)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Pin monitor sees the values driven during the previous cycle
	always @(posedge clk) begin
		int b;
		logic ack_now;
		cyc++;
		b = int'(sd_ba[0]);
		if (init_n) begin
			case (sd_cmd)
				CMD_PRECHARGE: begin
					assert (sd_a[AP_BIT] && !saw_mode && init_refreshes == 0) else begin
						$display("ERR %0t: PRECHARGE without A10 or out of init order",
							$time);
						errors++;
					end
					saw_precharge = 1'b1;
				end
				CMD_AUTO_REFRESH: begin
					assert (saw_precharge && !saw_mode) else begin
						$display("ERR %0t: AUTO_REFRESH out of init order", $time);
						errors++;
					end
					init_refreshes++;
				end
				CMD_LOAD_MODE: begin
					assert (sd_a == MODE_WORD && init_refreshes == 8) else begin
						$display("ERR %0t: LOAD_MODE a=%h after %0d refreshes",
							$time, sd_a, init_refreshes);
						errors++;
					end
					saw_mode = 1'b1;
				end
				CMD_ACTIVE: begin
					assert (saw_mode) else begin
						$display("ERR %0t: ACTIVE before LOAD_MODE", $time);
						errors++;
					end
					act_cyc[b] = cyc;
					act_open[b] = 1'b1;
					act_row[b] = sd_a;
				end
				CMD_READ, CMD_WRITE: begin
					assert (act_open[b] && cyc - act_cyc[b] == 2 && sd_a[AP_BIT]) else begin
						$display("ERR %0t: CAS on bank %0d is %0d cycles after ACTIVE, A10=%b",
							$time, b, cyc - act_cyc[b], sd_a[AP_BIT]);
						errors++;
					end
					act_open[b] = 1'b0;
					if (sd_cmd == CMD_READ && sd_dqm == 2'b11) begin
						// Row-walking refresh slot
						assert (act_row[b] == refresh_row_exp[b]) else begin
							$display("ERR %0t: refresh row %0d on bank %0d, expected %0d",
								$time, act_row[b], b, refresh_row_exp[b]);
							errors++;
						end
						if (refresh_count[b] > 0)
							assert (cyc - refresh_last[b] <= REFRESH_TICKS + REFRESH_MARGIN)
							else begin
								$display("ERR %0t: bank %0d refresh gap %0d cycles",
									$time, b, cyc - refresh_last[b]);
								errors++;
							end
						refresh_row_exp[b] = refresh_row_exp[b] + 1'b1;
						refresh_count[b]++;
						refresh_last[b] = cyc;
					end else
						ack_due[b] = act_cyc[b] + ((sd_cmd == CMD_READ) ? 6 : 3);
				end
				default: ;
			endcase
			// Data pins are driven only with a WRITE
			assert (!sd_dq_oe || sd_cmd == CMD_WRITE) else begin
				$display("ERR %0t: data pins driven with command %b", $time, sd_cmd);
				errors++;
			end
		end
		// Ack edges must land at their fixed offset from ACTIVE
		for (int p = 0; p < 2; p++) begin
			ack_now = (p == 0) ? cpu_ack : vid_ack;
			if (ack_now != prev_ack[p]) begin
				assert (cyc == ack_due[p]) else begin
					$display("ERR %0t: port %0d ack at cycle %0d, expected %0d",
						$time, p, cyc, ack_due[p]);
					errors++;
				end
				ack_due[p] = -1;
			end
			prev_ack[p] = ack_now;
		end
	end

	// Hang guard
	initial begin
		while (cyc < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic access(input int port, input logic we, input addr_t addr,
			input data_t wdata, output data_t rdata);
		@(posedge clk);
		if (port == 0) begin
			cpu_we <= we;
			cpu_addr <= addr;
			cpu_din <= wdata;
			cpu_req <= !cpu_req;
		end else begin
			vid_we <= we;
			vid_addr <= addr;
			vid_din <= wdata;
			vid_req <= !vid_req;
		end
		do
			@(posedge clk);
		while ((port == 0) ? (cpu_ack != cpu_req) : (vid_ack != vid_req));
		rdata = (port == 0) ? cpu_dout : vid_dout;
	endtask

	task automatic init_sequence();
		while (!saw_mode)
			@(posedge clk);
		assert (saw_precharge && init_refreshes == 8) else begin
			$display("ERR %0t: init saw %0d refreshes", $time, init_refreshes);
			errors++;
		end
	endtask

	task automatic write_read_cpu();
		addr_t addr;
		data_t wdata, rdata;
		addr = addr_t'($random(seed));
		wdata = data_t'($random(seed));
		access(0, 1'b1, addr, wdata, rdata);
		access(0, 1'b0, addr, '0, rdata);
		assert (rdata == wdata) else begin
			$display("ERR %0t: cpu read %h, expected %h", $time, rdata, wdata);
			errors++;
		end
		assert (model.peek(2'd0, addr[WORD_ADDR_BITS-1:COL_BITS], addr[COL_BITS-1:0]) == wdata)
		else begin
			$display("ERR %0t: model holds the wrong word at %h", $time, addr);
			errors++;
		end
	endtask

	// Reads expect the last word this port wrote to the address
	task automatic run_port(input int port);
		data_t rdata;
		for (int i = 0; i < NUM_OPS; i++) begin
			access(port, op_we[port][i], op_addr[port][i], op_data[port][i], rdata);
			if (!op_we[port][i])
				assert (rdata == op_data[port][i]) else begin
					$display("ERR %0t: port %0d read %h at %h, expected %h", $time, port,
						rdata, op_addr[port][i], op_data[port][i]);
					errors++;
				end
		end
	endtask

	task automatic two_port_traffic();
		data_t shadow [4];
		bit written [4];
		logic [1:0] idx;
		for (int k = 0; k < 4; k++)
			addr_table[k] = addr_t'($random(seed));
		// Both ports share the address set so a bank mix-up shows
		for (int p = 0; p < 2; p++) begin
			for (int k = 0; k < 4; k++)
				written[k] = 1'b0;
			for (int i = 0; i < NUM_OPS; i++) begin
				idx = 2'($random(seed));
				op_addr[p][i] = addr_table[idx];
				op_we[p][i] = !written[idx] || ($random(seed) & 1) != 0;
				if (op_we[p][i]) begin
					shadow[idx] = data_t'($random(seed));
					written[idx] = 1'b1;
				end
				op_data[p][i] = shadow[idx];
			end
		end
		fork
			run_port(0);
			run_port(1);
		join
	endtask

	task automatic cas_and_ack_timing();
		data_t d0, d1, rdata0, rdata1;
		d0 = data_t'($random(seed));
		d1 = data_t'($random(seed));
		// One known word per bank
		fork
			access(0, 1'b1, addr_table[0], d0, rdata0);
			access(1, 1'b1, addr_table[1], d1, rdata1);
		join
		// Read on one bank against a write on the other
		fork
			access(0, 1'b0, addr_table[0], '0, rdata0);
			access(1, 1'b1, addr_table[1], ~d1, rdata1);
		join
		assert (rdata0 == d0) else begin
			$display("ERR %0t: cpu read %h, expected %h", $time, rdata0, d0);
			errors++;
		end
		// vid read wins the slot and the cpu write has to skip the next one
		fork
			access(0, 1'b1, addr_table[0], ~d0, rdata0);
			access(1, 1'b0, addr_table[1], '0, rdata1);
		join
		assert (rdata1 == ~d1) else begin
			$display("ERR %0t: vid read %h, expected %h", $time, rdata1, ~d1);
			errors++;
		end
	endtask

	task automatic refresh_spacing();
		int c0, c1, stop;
		data_t rdata;
		c0 = refresh_count[0];
		c1 = refresh_count[1];
		repeat (3 * REFRESH_TICKS) @(posedge clk);
		assert (refresh_count[0] - c0 >= 2 && refresh_count[1] - c1 >= 2) else begin
			$display("ERR %0t: idle refreshes %0d and %0d", $time,
				refresh_count[0] - c0, refresh_count[1] - c1);
			errors++;
		end
		// Back-to-back traffic on both ports
		c0 = refresh_count[0];
		c1 = refresh_count[1];
		stop = cyc + 3 * REFRESH_TICKS;
		fork
			while (cyc < stop)
				access(0, 1'b0, addr_t'($random(seed)), '0, rdata);
			while (cyc < stop)
				access(1, 1'b0, addr_t'($random(seed)), '0, rdata);
		join
		assert (refresh_count[0] - c0 >= 1 && refresh_count[1] - c1 >= 1) else begin
			$display("ERR %0t: busy refreshes %0d and %0d", $time,
				refresh_count[0] - c0, refresh_count[1] - c1);
			errors++;
		end
	endtask

	initial begin
		seed = 32'hd3a9;
		errors = 0;
		cyc = 0;
		saw_precharge = 1'b0;
		saw_mode = 1'b0;
		init_refreshes = 0;
		for (int p = 0; p < 2; p++) begin
			act_cyc[p] = 0;
			act_open[p] = 1'b0;
			act_row[p] = '0;
			ack_due[p] = -1;
			prev_ack[p] = 1'b0;
			refresh_count[p] = 0;
			refresh_last[p] = 0;
			refresh_row_exp[p] = '0;
		end
		init_n = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_din = '0;
		vid_req = 1'b0;
		vid_we = 1'b0;
		vid_addr = '0;
		vid_din = '0;
		repeat (8) @(posedge clk);
		init_n <= 1'b1;

		init_sequence();
		write_read_cpu();
		two_port_traffic();
		cas_and_ack_timing();
		refresh_spacing();

		repeat (10) @(posedge clk);
		$display("Check errors: %0d, protocol errors: %0d", errors, model.proto_errors);
		if (errors == 0 && model.proto_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- compile.f
common/sdram_pkg.sv
common/bank_req_if.sv
hw/sdram_ctrl/refresh_timer.sv
hw/sdram_ctrl/bank_queue.sv
hw/sdram_ctrl/cmd_sequencer.sv
hw/sdram_ctrl/read_return.sv
hw/sdram_ctrl/sdram_ctrl.sv
tests/sdram_model.sv
tests/tb_sdram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_sdram_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_sdram_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1
